// File: rx_desc_pkg.sv
`default_nettype none

package rx_desc_pkg;

	////////////////////////////////////////////////////////////
	// Local descriptor RAM sizing
	////////////////////////////////////////////////////////////

	// Local descriptor RAM in dwords
	localparam int DESC_RAM_DWORDS = 1024;
	// Four dwords per descriptor
	localparam int DESC_MAX_NUM = DESC_RAM_DWORDS / 4;
	localparam int DESC_NUM_BITS = $clog2(DESC_MAX_NUM);
	// Longest fetch, bounded by the bus burst
	localparam int FETCH_MAX = 64;
	// Descriptor index to byte address, 16 bytes each
	localparam int DESC_BYTES_LOG = 4;
	// Status byte lives in the last dword
	localparam int WB_STATUS_OFFSET = 12;

	// Host ring index
	typedef logic [15:0] ring_ptr_t;
	// Local slot index
	typedef logic [DESC_NUM_BITS-1:0] slot_t;

	////////////////////////////////////////////////////////////
	// iDMA command words
	////////////////////////////////////////////////////////////

	// Beat 0 of every command
	typedef struct packed {
		logic write;
		logic [2:0] rsv;
		logic [11:0] bytes;
		logic [15:0] local_addr;
	} idma_cmd_hdr_t;

	// Beats 1 and 2 carry the host address halves instead
	typedef union packed {
		idma_cmd_hdr_t hdr;
		logic [31:0] addr;
	} idma_beat_u;

	// Host ring view after the last recompute
	typedef struct packed {
		ring_ptr_t fresh;
		ring_ptr_t limit;
		ring_ptr_t curr;
		ring_ptr_t head;
		logic busy;
	} ring_status_t;

	// Engine response bits 17:16
	typedef struct packed {
		logic delay_int;
		logic report_status;
	} desc_flags_t;

	// Local queue view, counts one bit wider than a slot
	typedef struct packed {
		logic [DESC_NUM_BITS:0] in_count;
		logic [DESC_NUM_BITS:0] out_count;
		logic [DESC_NUM_BITS:0] pending;
		logic [DESC_NUM_BITS:0] available;
		slot_t in_head;
		slot_t in_tail;
		slot_t out_head;
		desc_flags_t out_flags;
	} queue_status_t;

endpackage

`default_nettype wire

// File: host_ring.sv
`timescale 1ns/1ps
`default_nettype none

module host_ring import rx_desc_pkg::*;
(
	input logic aclk,
	input logic reset,
	input logic [63:0] rdba,
	input logic [12:0] rdlen,
	input ring_ptr_t rdh,
	input logic rdh_set,
	input ring_ptr_t rdt,
	input logic rdt_set,
	input logic [1:0] rdmts,
	input logic host_advance,
	input logic [DESC_NUM_BITS:0] fwd_count,
	input logic head_advance,
	output ring_status_t ring,
	output ring_ptr_t rdh_fb,
	output logic rxdmt0_req,
	output logic [63:0] wb_addr,
	output logic [63:0] rd_addr
);

	// Ring length in descriptors
	ring_ptr_t length;
	ring_ptr_t min_thresh;
	ring_ptr_t head;
	ring_ptr_t curr;
	ring_ptr_t tail;
	ring_ptr_t fresh;
	ring_ptr_t limit;
	ring_ptr_t limit_n0;
	// Unwrapped sums, one bit of headroom
	logic [16:0] head_n0;
	logic [16:0] curr_n0;
	logic [16:0] fresh_n0;
	logic [2:0] calc_stage;
	logic strobe;

	// Fold a sum below 2*len back into the ring
	function automatic ring_ptr_t wrap(input logic [16:0] value, input ring_ptr_t len);
		if (value >= {1'b0, len})
			return 16'(value - {1'b0, len});
		return value[15:0];
	endfunction

	assign length = {rdlen, 3'b000};
	// RXDMT0 level, half, quarter or eighth of the ring
	assign min_thresh = length >> (3'(rdmts) + 3'd1);
	assign strobe = rdh_set | rdt_set | host_advance | head_advance;

	////////////////////////////////////////////////////////////
	// Recompute pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge aclk)
	begin
		if (reset)
			calc_stage <= '0;
		else
			calc_stage <= {calc_stage[1:0], strobe};
	end

	// Raw pointer sums on the strobe
	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			head_n0 <= '0;
			curr_n0 <= '0;
		end
		else if (rdh_set)
		begin
			head_n0 <= {1'b0, rdh};
			curr_n0 <= {1'b0, rdh};
		end
		else
		begin
			if (head_advance)
				head_n0 <= {1'b0, head} + 17'd1;
			if (host_advance)
				curr_n0 <= {1'b0, curr} + 17'(fwd_count);
		end
	end

	// Stage 0, wrapped pointers; tail taken as written
	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			head <= '0;
			curr <= '0;
			tail <= '0;
		end
		else
		begin
			if (calc_stage[0])
			begin
				head <= wrap(head_n0, length);
				curr <= wrap(curr_n0, length);
			end
			if (rdt_set)
				tail <= rdt;
		end
	end

	// Stage 1, distances before wrap
	always_ff @(posedge aclk)
	begin
		if (calc_stage[1])
		begin
			fresh_n0 <= {1'b0, tail} + {1'b0, length} - {1'b0, curr};
			limit_n0 <= length - curr;
		end
	end

	// Stage 2, results stored and threshold checked
	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			fresh <= '0;
			limit <= '0;
			rxdmt0_req <= 1'b0;
		end
		else
		begin
			rxdmt0_req <= calc_stage[2] && (wrap(fresh_n0, length) < min_thresh);
			if (calc_stage[2])
			begin
				fresh <= wrap(fresh_n0, length);
				limit <= limit_n0;
			end
		end
	end

	// Host byte addresses, write-back points at the status byte
	always_ff @(posedge aclk)
	begin
		wb_addr <= rdba + (64'(head) << DESC_BYTES_LOG) + 64'(WB_STATUS_OFFSET);
		rd_addr <= rdba + (64'(curr) << DESC_BYTES_LOG);
	end

	assign ring = '{fresh: fresh, limit: limit, curr: curr, head: head, busy: |calc_stage};
	assign rdh_fb = head;

	// Sequencer never forwards past the posted tail
	assert property (@(posedge aclk) disable iff (reset)
		host_advance |-> 16'(fwd_count) <= fresh)
		else $error("forward of %0d exceeds fresh count %0d", fwd_count, fresh);

endmodule

`default_nettype wire

// File: local_desc_queue.sv
`timescale 1ns/1ps
`default_nettype none

module local_desc_queue import rx_desc_pkg::*;
(
	input logic aclk,
	input logic reset,
	input logic in_enqueue,
	input logic [DESC_NUM_BITS:0] enq_count,
	input logic in_dequeue,
	input logic out_enqueue,
	input desc_flags_t out_flags,
	input logic out_dequeue,
	output queue_status_t queue
);

	// Input queue, fetched but not yet with the engine
	slot_t in_head;
	slot_t in_tail;
	logic [DESC_NUM_BITS:0] in_count;
	// Output queue, back from the engine and not retired
	slot_t out_head;
	slot_t out_tail;
	logic [DESC_NUM_BITS:0] out_count;
	// Slots in use overall and slots free
	logic [DESC_NUM_BITS:0] pending;
	logic [DESC_NUM_BITS:0] available;
	logic [DESC_NUM_BITS:0] enq_incr;
	// RS and IDE per slot
	desc_flags_t flag_mem [DESC_MAX_NUM];

	assign enq_incr = in_enqueue ? enq_count : '0;

	////////////////////////////////////////////////////////////
	// Queue pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			in_head <= '0;
			in_tail <= '0;
			in_count <= '0;
		end
		else
		begin
			in_tail <= in_tail + slot_t'(enq_incr);
			if (in_dequeue)
				in_head <= in_head + 1'b1;
			in_count <= in_count + enq_incr - (DESC_NUM_BITS+1)'(in_dequeue);
		end
	end

	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			out_head <= '0;
			out_tail <= '0;
			out_count <= '0;
		end
		else
		begin
			if (out_enqueue)
				out_tail <= out_tail + 1'b1;
			if (out_dequeue)
				out_head <= out_head + 1'b1;
			out_count <= out_count + (DESC_NUM_BITS+1)'(out_enqueue)
				- (DESC_NUM_BITS+1)'(out_dequeue);
		end
	end

	// A slot is held from fetch until retire
	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			pending <= '0;
			available <= (DESC_NUM_BITS+1)'(DESC_MAX_NUM);
		end
		else
		begin
			pending <= pending + enq_incr - (DESC_NUM_BITS+1)'(out_dequeue);
			available <= available - enq_incr + (DESC_NUM_BITS+1)'(out_dequeue);
		end
	end

	// Flags in at the output tail
	always_ff @(posedge aclk)
	begin
		if (out_enqueue)
			flag_mem[out_tail] <= out_flags;
	end

	// Head flags read straight through, valid as soon as out_count is
	assign queue = '{in_count: in_count, out_count: out_count, pending: pending,
		available: available, in_head: in_head, in_tail: in_tail, out_head: out_head,
		out_flags: flag_mem[out_head]};

	// Fetch sized against free slots, pending bounded by the slot count
	assert property (@(posedge aclk) disable iff (reset)
		(in_enqueue |-> enq_count <= available) and (pending <= DESC_MAX_NUM))
		else $error("slot accounting broken, pending %0d available %0d", pending, available);

endmodule

`default_nettype wire

// File: idma_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module idma_sequencer import rx_desc_pkg::*;
(
	input logic aclk,
	input logic reset,
	input logic en,
	input logic [5:0] pthresh,
	input logic [5:0] hthresh,
	input ring_status_t ring,
	input logic [63:0] wb_addr,
	input logic [63:0] rd_addr,
	input queue_status_t queue,
	output idma_beat_u idma_m_tdata,
	output logic idma_m_tvalid,
	output logic idma_m_tlast,
	input logic idma_m_tready,
	input logic idma_s_tvalid,
	input logic idma_s_tlast,
	output logic idma_s_tready,
	output logic host_advance,
	output logic [DESC_NUM_BITS:0] fwd_count,
	output logic head_advance,
	output logic in_enqueue,
	output logic [DESC_NUM_BITS:0] enq_count,
	output logic out_dequeue
);

	typedef enum logic [1:0] {S_READY, S_CMD, S_ACK, S_DONE} state_t;

	state_t state;
	// Current command is a status write-back
	logic is_wb;
	logic [1:0] beat;
	logic [DESC_NUM_BITS:0] fetch_num;
	ring_ptr_t fetch_min;
	logic fetch_go;
	logic beat_take;
	logic resp_done;
	logic [63:0] host_addr;
	idma_cmd_hdr_t hdr_next;

	// Fetch size, smallest of limit, fresh, free slots and burst cap
	always_comb
	begin
		fetch_min = ring.limit;
		if (ring.fresh < fetch_min)
			fetch_min = ring.fresh;
		if (16'(queue.available) < fetch_min)
			fetch_min = 16'(queue.available);
		if (16'(FETCH_MAX) < fetch_min)
			fetch_min = 16'(FETCH_MAX);
	end

	// Prefetch below pthresh, or refill an empty local ring
	assign fetch_go = ((pthresh == 6'd0 || queue.pending < pthresh) && ring.fresh > hthresh)
		|| (queue.pending == '0 && ring.fresh != '0);

	// Header, write-back wins whenever output slots wait
	always_comb
	begin
		hdr_next.rsv = '0;
		if (queue.out_count != '0)
		begin
			hdr_next.write = 1'b1;
			hdr_next.bytes = 12'd1;
			hdr_next.local_addr = (16'(queue.out_head) << DESC_BYTES_LOG)
				+ 16'(WB_STATUS_OFFSET);
		end
		else
		begin
			hdr_next.write = 1'b0;
			hdr_next.bytes = 12'(fetch_min << DESC_BYTES_LOG);
			hdr_next.local_addr = 16'(queue.in_tail) << DESC_BYTES_LOG;
		end
	end

	assign host_addr = is_wb ? wb_addr : rd_addr;
	assign beat_take = idma_m_tvalid & idma_m_tready;
	// Write-back done on any beat, fetch on the last
	assign resp_done = idma_s_tready & idma_s_tvalid & (is_wb | idma_s_tlast);
	assign fwd_count = fetch_num;
	assign enq_count = fetch_num;

	////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			state <= S_READY;
			is_wb <= 1'b0;
			beat <= 2'd0;
			idma_m_tvalid <= 1'b0;
			idma_m_tlast <= 1'b0;
			idma_s_tready <= 1'b0;
			host_advance <= 1'b0;
			head_advance <= 1'b0;
			in_enqueue <= 1'b0;
			out_dequeue <= 1'b0;
		end
		else
		begin
			// Update strobes last one cycle
			host_advance <= 1'b0;
			head_advance <= 1'b0;
			in_enqueue <= 1'b0;
			out_dequeue <= 1'b0;
			case (state)
				S_READY:
				begin
					// Wait out any ring recompute
					if (en && !ring.busy)
					begin
						if (queue.out_count != '0 && !queue.out_flags.report_status)
						begin
							// No status report, retire directly
							head_advance <= 1'b1;
							out_dequeue <= 1'b1;
							state <= S_DONE;
						end
						else if (queue.out_count != '0 || fetch_go)
						begin
							is_wb <= queue.out_count != '0;
							beat <= 2'd0;
							idma_m_tvalid <= 1'b1;
							state <= S_CMD;
						end
					end
				end
				S_CMD:
				begin
					if (beat_take)
					begin
						beat <= beat + 2'd1;
						if (beat == 2'd1)
							idma_m_tlast <= 1'b1;
						if (beat == 2'd2)
						begin
							idma_m_tvalid <= 1'b0;
							idma_m_tlast <= 1'b0;
							idma_s_tready <= 1'b1;
							state <= S_ACK;
						end
					end
				end
				S_ACK:
				begin
					if (resp_done)
					begin
						idma_s_tready <= 1'b0;
						head_advance <= is_wb;
						out_dequeue <= is_wb;
						host_advance <= !is_wb;
						in_enqueue <= !is_wb;
						state <= S_DONE;
					end
				end
				// Strobes out; ring busy shows from the next cycle
				default:
					state <= S_READY;
			endcase
		end
	end

	// Beat data moves only on acceptance
	always_ff @(posedge aclk)
	begin
		if (state == S_READY)
		begin
			idma_m_tdata.hdr <= hdr_next;
			fetch_num <= (DESC_NUM_BITS+1)'(fetch_min);
		end
		else if (state == S_CMD && beat_take)
			idma_m_tdata.addr <= (beat == 2'd0) ? host_addr[31:0] : host_addr[63:32];
	end

	// Fetch start conditions leave free slots and fresh work
	assert property (@(posedge aclk) disable iff (reset)
		$rose(idma_m_tvalid) && !is_wb |-> fetch_num != '0)
		else $error("fetch command issued with zero size");

endmodule

`default_nettype wire

// File: engine_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module engine_dispatch import rx_desc_pkg::*;
(
	input logic aclk,
	input logic reset,
	input logic en,
	input queue_status_t queue,
	output logic [31:0] reng_m_tdata,
	output logic reng_m_tvalid,
	output logic reng_m_tlast,
	input logic reng_m_tready,
	input logic [31:0] reng_s_tdata,
	input logic reng_s_tvalid,
	input logic reng_s_tlast,
	output logic reng_s_tready,
	output logic in_dequeue,
	output logic out_enqueue,
	output desc_flags_t out_flags
);

	typedef enum logic [1:0] {E_READY, E_CMD, E_ACK} state_t;

	state_t state;
	logic resp_take;

	// Single-beat commands
	assign reng_m_tlast = 1'b1;
	assign resp_take = reng_s_tready & reng_s_tvalid & reng_s_tlast;

	////////////////////////////////////////////////////////////
	// One descriptor in flight
	////////////////////////////////////////////////////////////

	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			state <= E_READY;
			reng_m_tvalid <= 1'b0;
			reng_s_tready <= 1'b0;
			in_dequeue <= 1'b0;
			out_enqueue <= 1'b0;
		end
		else
		begin
			in_dequeue <= 1'b0;
			out_enqueue <= 1'b0;
			case (state)
				E_READY:
				begin
					if (en && queue.in_count != '0)
					begin
						reng_m_tvalid <= 1'b1;
						state <= E_CMD;
					end
				end
				E_CMD:
				begin
					// Slot leaves the input queue once taken
					if (reng_m_tready)
					begin
						reng_m_tvalid <= 1'b0;
						reng_s_tready <= 1'b1;
						in_dequeue <= 1'b1;
						state <= E_ACK;
					end
				end
				default:
				begin
					if (resp_take)
					begin
						reng_s_tready <= 1'b0;
						out_enqueue <= 1'b1;
						state <= E_READY;
					end
				end
			endcase
		end
	end

	// Head slot byte address, flags from bits 17:16
	always_ff @(posedge aclk)
	begin
		if (state == E_READY)
			reng_m_tdata <= 32'(16'(queue.in_head) << DESC_BYTES_LOG);
		if (resp_take)
			out_flags <= desc_flags_t'(reng_s_tdata[17:16]);
	end

	// Command held until the engine takes it
	assert property (@(posedge aclk) disable iff (reset)
		reng_m_tvalid && !reng_m_tready |=> reng_m_tvalid)
		else $error("engine command dropped before acceptance");

endmodule

`default_nettype wire

// File: rx_desc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rx_desc_ctrl import rx_desc_pkg::*;
(
	input logic aclk,
	input logic reset,

	// Ring registers
	input logic en,
	input logic [63:0] rdba,
	input logic [12:0] rdlen,
	input ring_ptr_t rdh,
	input logic rdh_set,
	output ring_ptr_t rdh_fb,
	input ring_ptr_t rdt,
	input logic rdt_set,
	input logic [5:0] pthresh,
	input logic [5:0] hthresh,
	input logic [1:0] rdmts,
	output logic rxdmt0_req,

	// iDMA command and response
	output idma_beat_u idma_m_tdata,
	output logic idma_m_tvalid,
	output logic idma_m_tlast,
	input logic idma_m_tready,
	input logic idma_s_tvalid,
	input logic idma_s_tlast,
	output logic idma_s_tready,

	// Receive engine command and response
	output logic [31:0] reng_m_tdata,
	output logic reng_m_tvalid,
	output logic reng_m_tlast,
	input logic reng_m_tready,
	input logic [31:0] reng_s_tdata,
	input logic reng_s_tvalid,
	input logic reng_s_tlast,
	output logic reng_s_tready
);

	ring_status_t ring;
	queue_status_t queue;
	logic [63:0] wb_addr;
	logic [63:0] rd_addr;
	logic host_advance;
	logic head_advance;
	logic [DESC_NUM_BITS:0] fwd_count;
	logic in_enqueue;
	logic [DESC_NUM_BITS:0] enq_count;
	logic out_dequeue;
	logic in_dequeue;
	logic out_enqueue;
	desc_flags_t out_flags;

	////////////////////////////////////////////////////////////
	// Host ring and local queue state
	////////////////////////////////////////////////////////////

	host_ring u_host_ring (
		.aclk(aclk), .reset(reset), .rdba(rdba), .rdlen(rdlen),
		.rdh(rdh), .rdh_set(rdh_set), .rdt(rdt), .rdt_set(rdt_set), .rdmts(rdmts),
		.host_advance(host_advance), .fwd_count(fwd_count), .head_advance(head_advance),
		.ring(ring), .rdh_fb(rdh_fb), .rxdmt0_req(rxdmt0_req),
		.wb_addr(wb_addr), .rd_addr(rd_addr)
	);

	local_desc_queue u_local_desc_queue (
		.aclk(aclk), .reset(reset),
		.in_enqueue(in_enqueue), .enq_count(enq_count), .in_dequeue(in_dequeue),
		.out_enqueue(out_enqueue), .out_flags(out_flags), .out_dequeue(out_dequeue),
		.queue(queue)
	);

	////////////////////////////////////////////////////////////
	// iDMA and engine sides
	////////////////////////////////////////////////////////////

	idma_sequencer u_idma_sequencer (
		.aclk(aclk), .reset(reset), .en(en), .pthresh(pthresh), .hthresh(hthresh),
		.ring(ring), .wb_addr(wb_addr), .rd_addr(rd_addr), .queue(queue),
		.idma_m_tdata(idma_m_tdata), .idma_m_tvalid(idma_m_tvalid),
		.idma_m_tlast(idma_m_tlast), .idma_m_tready(idma_m_tready),
		.idma_s_tvalid(idma_s_tvalid), .idma_s_tlast(idma_s_tlast),
		.idma_s_tready(idma_s_tready),
		.host_advance(host_advance), .fwd_count(fwd_count), .head_advance(head_advance),
		.in_enqueue(in_enqueue), .enq_count(enq_count), .out_dequeue(out_dequeue)
	);

	engine_dispatch u_engine_dispatch (
		.aclk(aclk), .reset(reset), .en(en), .queue(queue),
		.reng_m_tdata(reng_m_tdata), .reng_m_tvalid(reng_m_tvalid),
		.reng_m_tlast(reng_m_tlast), .reng_m_tready(reng_m_tready),
		.reng_s_tdata(reng_s_tdata), .reng_s_tvalid(reng_s_tvalid),
		.reng_s_tlast(reng_s_tlast), .reng_s_tready(reng_s_tready),
		.in_dequeue(in_dequeue), .out_enqueue(out_enqueue), .out_flags(out_flags)
	);

endmodule

`default_nettype wire

// File: tb_rx_desc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rx_desc_ctrl import rx_desc_pkg::*; ();

	// Tail writes and the longest idle gap after each
	localparam int NUM_WRITES = 40;
	localparam int MAX_GAP = 24;
	localparam int STIM_CYCLES = NUM_WRITES * MAX_GAP + 300;
	localparam int TIMEOUT_CYCLES = 40 * STIM_CYCLES;
	localparam int QUIET_CYCLES = 24;

	logic aclk;
	logic reset;
	logic en;
	logic [63:0] rdba;
	logic [12:0] rdlen;
	ring_ptr_t rdh;
	logic rdh_set;
	ring_ptr_t rdh_fb;
	ring_ptr_t rdt;
	logic rdt_set;
	logic [5:0] pthresh;
	logic [5:0] hthresh;
	logic [1:0] rdmts;
	logic rxdmt0_req;
	idma_beat_u idma_m_tdata;
	logic idma_m_tvalid;
	logic idma_m_tlast;
	logic idma_m_tready;
	logic idma_s_tvalid;
	logic idma_s_tlast;
	logic idma_s_tready;
	logic [31:0] reng_m_tdata;
	logic reng_m_tvalid;
	logic reng_m_tlast;
	logic reng_m_tready;
	logic [31:0] reng_s_tdata;
	logic reng_s_tvalid;
	logic reng_s_tlast;
	logic reng_s_tready;

	// Model of the ring, the local slots and the queues
	int len = 16;
	int thresh = 1;
	logic [63:0] base = '0;
	int sw_tail = 0;
	int m_tail = 0;
	int m_curr = 0;
	int m_head = 0;
	int m_in_tail = 0;
	int fetched_q [$];
	int inflight_q [$];
	int out_slot_q [$];
	int out_rs_q [$];
	// Command beat tracking
	int cmd_beat = 0;
	idma_cmd_hdr_t cur_hdr;
	logic [63:0] exp_addr;
	// Responder bookkeeping, handshakes seen mid-cycle
	int idma_owed = 0;
	int eng_owed = 0;
	logic idma_hs = 1'b0;
	logic eng_hs = 1'b0;
	int pulses = 0;
	int fresh_hist [6];
	int quiet_count = 0;
	ring_ptr_t last_head = '0;
	int cycle_count = 0;

	rx_desc_ctrl dut0 (
		.aclk(aclk), .reset(reset), .en(en), .rdba(rdba), .rdlen(rdlen),
		.rdh(rdh), .rdh_set(rdh_set), .rdh_fb(rdh_fb), .rdt(rdt), .rdt_set(rdt_set),
		.pthresh(pthresh), .hthresh(hthresh), .rdmts(rdmts), .rxdmt0_req(rxdmt0_req),
		.idma_m_tdata(idma_m_tdata), .idma_m_tvalid(idma_m_tvalid),
		.idma_m_tlast(idma_m_tlast), .idma_m_tready(idma_m_tready),
		.idma_s_tvalid(idma_s_tvalid), .idma_s_tlast(idma_s_tlast),
		.idma_s_tready(idma_s_tready),
		.reng_m_tdata(reng_m_tdata), .reng_m_tvalid(reng_m_tvalid),
		.reng_m_tlast(reng_m_tlast), .reng_m_tready(reng_m_tready),
		.reng_s_tdata(reng_s_tdata), .reng_s_tvalid(reng_s_tvalid),
		.reng_s_tlast(reng_s_tlast), .reng_s_tready(reng_s_tready)
	);

	initial
	begin
		aclk = 1'b0;
		forever #50 aclk = ~aclk;
	end

	////////////////////////////////////////////////////////////
	// Failure reporting and common steps
	////////////////////////////////////////////////////////////

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
			report_failure($sformatf("ERROR at %0t: %s expected 0x%0h actual 0x%0h",
				$time, name, expected, actual));
	endtask

	// Inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge aclk);
		#1;
	endtask

	// Descriptors owned by software but not yet fetched
	function automatic int ring_fresh();
		return (m_tail + len - m_curr) % len;
	endfunction

	// Room left for software before the tail meets the head
	function automatic int ring_room();
		return len - 1 - ((sw_tail + len - int'(rdh_fb)) % len);
	endfunction

	task automatic write_tail(input int adv);
		sw_tail = (sw_tail + adv) % len;
		rdt = 16'(sw_tail);
		rdt_set = 1'b1;
		next_cycle();
		rdt_set = 1'b0;
	endtask

	// Descriptors without report status retire silently, in order
	task automatic retire_plain();
		while (out_rs_q.size() != 0 && out_rs_q[0] == 0)
		begin
			void'(out_rs_q.pop_front());
			void'(out_slot_q.pop_front());
			m_head = (m_head + 1) % len;
		end
	endtask

	task automatic wait_quiet();
		next_cycle();
		while (quiet_count < QUIET_CYCLES)
			next_cycle();
	endtask

	////////////////////////////////////////////////////////////
	// Responders
	////////////////////////////////////////////////////////////

	task automatic idma_responder();
		forever
		begin
			next_cycle();
			idma_m_tready = ($urandom % 4) != 0;
			if (idma_hs)
				idma_s_tvalid = 1'b0;
			else if (!idma_s_tvalid && idma_owed > 0 && ($urandom % 4) == 0)
				idma_s_tvalid = 1'b1;
		end
	endtask

	// Random report status and delay interrupt in bits 17:16
	task automatic engine_responder();
		forever
		begin
			next_cycle();
			reng_m_tready = ($urandom % 3) != 0;
			if (eng_hs)
				reng_s_tvalid = 1'b0;
			else if (!reng_s_tvalid && eng_owed > 0 && ($urandom % 3) == 0)
			begin
				reng_s_tdata = {14'd0, 2'($urandom), 16'd0};
				reng_s_tvalid = 1'b1;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Monitor and model, sampled mid-cycle
	////////////////////////////////////////////////////////////

	task automatic fetch_header_seen();
		int count;
		count = int'(cur_hdr.bytes) >> DESC_BYTES_LOG;
		compare_value("fetch bytes", 64'(count * 16), 64'(cur_hdr.bytes));
		compare_value("fetch local_addr", 64'(m_in_tail * 16), 64'(cur_hdr.local_addr));
		if (count == 0 || count > FETCH_MAX || count > ring_fresh() || count > len - m_curr)
			report_failure($sformatf("Fetch of %0d descriptors out of range at %0t, fresh %0d",
				count, $time, ring_fresh()));
		exp_addr = base + (64'(m_curr) << DESC_BYTES_LOG);
		for (int i = 0; i < count; i++)
			fetched_q.push_back((m_in_tail + i) % DESC_MAX_NUM);
		m_in_tail = (m_in_tail + count) % DESC_MAX_NUM;
		m_curr = (m_curr + count) % len;
	endtask

	task automatic writeback_header_seen();
		retire_plain();
		if (out_rs_q.size() == 0)
			report_failure($sformatf("Write-back at %0t with no descriptor holding report status",
				$time));
		compare_value("wb bytes", 64'd1, 64'(cur_hdr.bytes));
		compare_value("wb local_addr", 64'(out_slot_q[0] * 16 + WB_STATUS_OFFSET),
			64'(cur_hdr.local_addr));
		exp_addr = base + (64'(m_head) << DESC_BYTES_LOG) + 64'(WB_STATUS_OFFSET);
		void'(out_rs_q.pop_front());
		void'(out_slot_q.pop_front());
		m_head = (m_head + 1) % len;
	endtask

	task automatic idma_beat_seen();
		if (cmd_beat == 0)
		begin
			cur_hdr = idma_m_tdata.hdr;
			compare_value("idma_m_tlast", 64'd0, 64'(idma_m_tlast));
			if (cur_hdr.write)
				writeback_header_seen();
			else
				fetch_header_seen();
			cmd_beat = 1;
		end
		else if (cmd_beat == 1)
		begin
			compare_value("idma_m_tdata low", 64'(exp_addr[31:0]), 64'(idma_m_tdata.addr));
			compare_value("idma_m_tlast", 64'd0, 64'(idma_m_tlast));
			cmd_beat = 2;
		end
		else
		begin
			compare_value("idma_m_tdata high", 64'(exp_addr[63:32]), 64'(idma_m_tdata.addr));
			compare_value("idma_m_tlast", 64'd1, 64'(idma_m_tlast));
			idma_owed++;
			cmd_beat = 0;
		end
	endtask

	// Slots must reach the engine in fetch order
	task automatic engine_command_seen();
		int slot;
		if (fetched_q.size() == 0)
			report_failure($sformatf("Engine command at %0t for a slot that was never fetched",
				$time));
		slot = fetched_q.pop_front();
		compare_value("reng_m_tdata", 64'(slot * 16), 64'(reng_m_tdata));
		compare_value("reng_m_tlast", 64'd1, 64'(reng_m_tlast));
		inflight_q.push_back(slot);
		eng_owed++;
	endtask

	always @(negedge aclk)
	begin
		logic low;
		idma_hs = idma_s_tvalid && idma_s_tready;
		eng_hs = reng_s_tvalid && reng_s_tready && reng_s_tlast;
		if (!reset)
		begin
			if (rdt_set)
				m_tail = int'(rdt);
			if (idma_m_tvalid && idma_m_tready)
				idma_beat_seen();
			if (reng_m_tvalid && reng_m_tready)
				engine_command_seen();
			if (idma_hs)
				idma_owed--;
			if (eng_hs)
			begin
				out_slot_q.push_back(inflight_q.pop_front());
				out_rs_q.push_back(int'(reng_s_tdata[16]));
				eng_owed--;
			end
			// Recent fresh counts, the pulse lags a tail write by a few cycles
			for (int i = 5; i > 0; i--)
				fresh_hist[i] = fresh_hist[i-1];
			fresh_hist[0] = ring_fresh();
			if (rxdmt0_req)
			begin
				pulses++;
				low = 1'b0;
				foreach (fresh_hist[i])
					if (fresh_hist[i] < thresh)
						low = 1'b1;
				if (!low)
					report_failure($sformatf("RXDMT0 pulse at %0t with fresh %0d not below %0d",
						$time, ring_fresh(), thresh));
			end
			// Quiet means no handshake pending and the head standing still
			if (!idma_m_tvalid && !idma_s_tready && !reng_m_tvalid && !reng_s_tready
				&& idma_owed == 0 && eng_owed == 0 && fetched_q.size() == 0
				&& rdh_fb == last_head)
				quiet_count++;
			else
				quiet_count = 0;
			last_head = rdh_fb;
		end
	end

	always @(posedge aclk)
	begin
		cycle_count++;
		if (cycle_count == TIMEOUT_CYCLES)
			report_failure($sformatf("Timeout, run still busy after %0d cycles", cycle_count));
	end

	////////////////////////////////////////////////////////////
	// Register stimulus
	////////////////////////////////////////////////////////////

	initial
	begin
		int seed;
		int room;
		int start_pulses;
		logic got;
		seed = $urandom(40);
		foreach (fresh_hist[i])
			fresh_hist[i] = 0;
		reset = 1'b1;
		en = 1'b0;
		rdba = '0;
		rdlen = 13'd2;
		rdh = '0;
		rdh_set = 1'b0;
		rdt = '0;
		rdt_set = 1'b0;
		pthresh = '0;
		hthresh = '0;
		rdmts = '0;
		idma_m_tready = 1'b0;
		idma_s_tvalid = 1'b0;
		idma_s_tlast = 1'b1;
		reng_m_tready = 1'b0;
		reng_s_tdata = '0;
		reng_s_tvalid = 1'b0;
		reng_s_tlast = 1'b1;
		repeat (10) @(posedge aclk);
		#1;
		reset = 1'b0;
		fork
			idma_responder();
			engine_responder();
		join_none

		// Random ring of 16 to 64 descriptors, head at zero
		rdba = {$urandom, $urandom} & ~64'hf;
		rdlen = 13'(2 + $urandom % 7);
		rdmts = 2'($urandom);
		pthresh = 6'($urandom % 16);
		hthresh = 6'($urandom % 8);
		base = rdba;
		len = int'(rdlen) * 8;
		thresh = len >> (int'(rdmts) + 1);
		rdh = '0;
		rdh_set = 1'b1;
		next_cycle();
		rdh_set = 1'b0;
		repeat (5) next_cycle();
		en = 1'b1;

		for (int n = 0; n < NUM_WRITES; n++)
		begin
			room = ring_room();
			if (room > 0)
				write_tail(1 + $urandom % room);
			repeat ($urandom % MAX_GAP) next_cycle();
		end
		wait_quiet();
		retire_plain();
		compare_value("fresh", 64'd0, 64'(ring_fresh()));
		if (out_rs_q.size() != 0)
			report_failure("A descriptor with report status retired without a write-back");
		compare_value("rdh_fb", 64'(m_head), 64'(rdh_fb));

		// Idle tail write below the threshold
		start_pulses = pulses;
		write_tail(thresh > 1 ? $urandom % thresh : 0);
		got = 1'b0;
		repeat (20)
		begin
			next_cycle();
			if (pulses > start_pulses)
				got = 1'b1;
		end
		if (!got)
			report_failure("No RXDMT0 pulse followed an idle tail write below the threshold");
		wait_quiet();
		retire_plain();
		compare_value("rdh_fb", 64'(m_head), 64'(rdh_fb));

		// Disabled controller ignores new work
		en = 1'b0;
		next_cycle();
		write_tail(1 + $urandom % ring_room());
		repeat (60)
		begin
			next_cycle();
			compare_value("idma_m_tvalid", 64'd0, 64'(idma_m_tvalid));
			compare_value("reng_m_tvalid", 64'd0, 64'(reng_m_tvalid));
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
rx_desc_pkg.sv
host_ring.sv
local_desc_queue.sv
idma_sequencer.sv
engine_dispatch.sv
rx_desc_ctrl.sv
tb_rx_desc_ctrl.sv

// File: Bender.yml
package:
  name: rx_desc_ctrl

sources:
  - files:
      - rx_desc_pkg.sv
      - host_ring.sv
      - local_desc_queue.sv
      - idma_sequencer.sv
      - engine_dispatch.sv
      - rx_desc_ctrl.sv
  - target: test
    files:
      - tb_rx_desc_ctrl.sv
